/* logic/bridge_settings.svh */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// data widths on both sides of the bridge
`define BRIDGE_STREAM_W 64
`define BRIDGE_LITE_W 256
`define BRIDGE_BEATS 4
// beat index width and beat count width
`define BRIDGE_LEN_W 2
`define BRIDGE_CNT_W (`BRIDGE_LEN_W + 1)

// flat header layout: type | size | addr
`define BRIDGE_HDR_W 38
`define BRIDGE_TYPE_LSB 35
`define BRIDGE_TYPE_W 3
`define BRIDGE_SIZE_LSB 32
`define BRIDGE_SIZE_W 3
`define BRIDGE_ADDR_W 32

// message type codes, one mask bit per code
`define BRIDGE_MASK_W 8
`define BRIDGE_MSG_RD 0
`define BRIDGE_MSG_WR 1
`define BRIDGE_MSG_UC_RD 2
`define BRIDGE_MSG_UC_WR 3

// types that carry data on requests and on responses
`define BRIDGE_REQ_PAYLOAD_MASK ((8'd1 << `BRIDGE_MSG_WR) | (8'd1 << `BRIDGE_MSG_UC_WR))
`define BRIDGE_RESP_PAYLOAD_MASK ((8'd1 << `BRIDGE_MSG_RD) | (8'd1 << `BRIDGE_MSG_UC_RD))

`endif

/* logic/bridge_pkg.sv */
`default_nettype none

`include "bridge_settings.svh"

package bridge_pkg;

  // one wide word, seen whole or as stream beats (beat 0 in the low bits)
  typedef union packed {
    logic [`BRIDGE_LITE_W-1:0] word;
    logic [`BRIDGE_BEATS-1:0][`BRIDGE_STREAM_W-1:0] beat;
  } lite_data_u;

  // number of stream beats for one message
  function automatic logic [`BRIDGE_CNT_W-1:0] beat_count
    (
    input logic [`BRIDGE_HDR_W-1:0] hdr,
    input logic [`BRIDGE_MASK_W-1:0] mask
    );
    logic [`BRIDGE_TYPE_W-1:0] msg_type;
    logic [`BRIDGE_SIZE_W-1:0] size;
    logic [(1 << `BRIDGE_SIZE_W)-1:0] bytes;
    logic [(1 << `BRIDGE_SIZE_W)-1:0] beats;
    msg_type = hdr[`BRIDGE_TYPE_LSB +: `BRIDGE_TYPE_W];
    size = hdr[`BRIDGE_SIZE_LSB +: `BRIDGE_SIZE_W];
    // size is log2 of the byte count
    bytes = '0;
    bytes[size] = 1'b1;
    beats = bytes >> $clog2(`BRIDGE_STREAM_W / 8);
    if (!mask[msg_type] || (beats == '0))
      beats = 1;
    else if (beats > `BRIDGE_BEATS)
      beats = `BRIDGE_BEATS;
    return beats[`BRIDGE_CNT_W-1:0];
  endfunction

endpackage

`default_nettype wire

/* logic/msg_one_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module msg_one_fifo
  (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  logic [`BRIDGE_HDR_W-1:0] data_i,
  input  logic                     v_i,
  output logic                     ready_o,

  output logic [`BRIDGE_HDR_W-1:0] data_o,
  output logic                     v_o,
  input  logic                     yumi_i
  );

  logic                     full_r;
  logic [`BRIDGE_HDR_W-1:0] data_r;

  // single slot, no bypass
  assign ready_o = ~full_r;
  assign v_o = full_r;
  assign data_o = data_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      full_r <= 1'b0;
    else if (v_i & ready_o)
      full_r <= 1'b1;
    else if (yumi_i)
      full_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i & ready_o)
      data_r <= data_i;
  end

endmodule

`default_nettype wire

/* logic/stream_sipo_dynamic.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module stream_sipo_dynamic
  import bridge_pkg::*;
  (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic [`BRIDGE_STREAM_W-1:0] data_i,
  // beats minus one, sampled on the first beat
  input  logic [`BRIDGE_LEN_W-1:0]    len_i,
  input  logic                        v_i,
  output logic                        ready_o,

  output lite_data_u                  data_o,
  output logic                        v_o,
  input  logic                        yumi_i
  );

  logic [`BRIDGE_LEN_W-1:0] cnt_r;
  logic [`BRIDGE_LEN_W-1:0] len_r;
  logic [`BRIDGE_LEN_W-1:0] len_cur;
  logic                     full_r;
  logic                     accept;
  logic                     first_beat;
  logic                     final_beat;
  lite_data_u               data_r;

  assign ready_o = ~full_r;
  assign v_o = full_r;
  assign data_o = data_r;

  assign accept = v_i & ready_o;
  assign first_beat = (cnt_r == '0);
  // on the first beat the length comes straight from the input
  assign len_cur = first_beat ? len_i : len_r;
  assign final_beat = (cnt_r == len_cur);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_r <= '0;
      len_r <= '0;
      full_r <= 1'b0;
    end
    else if (yumi_i)
    begin
      cnt_r <= '0;
      full_r <= 1'b0;
    end
    else if (accept)
    begin
      if (first_beat)
        len_r <= len_i;
      // counter parks on the final beat until the take
      if (final_beat)
        full_r <= 1'b1;
      else
        cnt_r <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      // start of a message, clear beats a short message leaves unused
      if (first_beat)
      begin
        for (int k = 1; k < `BRIDGE_BEATS; k++)
        begin
          data_r.beat[k] <= '0;
        end
      end
      data_r.beat[cnt_r] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* logic/stream_to_lite.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module stream_to_lite
  import bridge_pkg::*;
#(
  parameter logic [`BRIDGE_MASK_W-1:0] payload_mask_p = `BRIDGE_REQ_PAYLOAD_MASK
)
  (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // narrow stream side
  input  logic [`BRIDGE_HDR_W-1:0]    in_hdr_i,
  input  logic [`BRIDGE_STREAM_W-1:0] in_data_i,
  input  logic                        in_v_i,
  output logic                        in_ready_o,

  // wide lite side
  output logic [`BRIDGE_HDR_W-1:0]    out_hdr_o,
  output lite_data_u                  out_data_o,
  output logic                        out_v_o,
  input  logic                        out_ready_i
  );

  logic [`BRIDGE_CNT_W-1:0] count;
  logic [`BRIDGE_CNT_W-1:0] count_m1;
  logic [`BRIDGE_LEN_W-1:0] len;
  logic                     take;
  logic                     fifo_v_lo;
  logic                     sipo_ready_lo;
  logic                     sipo_v_lo;

  assign count = beat_count(in_hdr_i, payload_mask_p);
  assign count_m1 = count - 1'b1;
  assign len = count_m1[`BRIDGE_LEN_W-1:0];

  assign take = out_v_o & out_ready_i;

  // header slot fills on the first beat and stays full for the rest
  msg_one_fifo u_hdr_fifo
    (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (in_hdr_i),
    .v_i     (in_v_i & sipo_ready_lo),
    .ready_o (),
    .data_o  (out_hdr_o),
    .v_o     (fifo_v_lo),
    .yumi_i  (take)
    );

  stream_sipo_dynamic u_sipo
    (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (in_data_i),
    .len_i   (len),
    .v_i     (in_v_i),
    .ready_o (sipo_ready_lo),
    .data_o  (out_data_o),
    .v_o     (sipo_v_lo),
    .yumi_i  (take)
    );

  // the header slot fills and drains in step with the gatherer
  assign in_ready_o = sipo_ready_lo;
  assign out_v_o = sipo_v_lo & fifo_v_lo;

endmodule

`default_nettype wire

/* logic/lite_to_stream.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module lite_to_stream
  import bridge_pkg::*;
#(
  parameter logic [`BRIDGE_MASK_W-1:0] payload_mask_p = `BRIDGE_RESP_PAYLOAD_MASK
)
  (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // wide lite side
  input  logic [`BRIDGE_HDR_W-1:0]    in_hdr_i,
  input  lite_data_u                  in_data_i,
  input  logic                        in_v_i,
  output logic                        in_ready_o,

  // narrow stream side
  output logic [`BRIDGE_HDR_W-1:0]    out_hdr_o,
  output logic [`BRIDGE_STREAM_W-1:0] out_data_o,
  output logic                        out_last_o,
  output logic                        out_v_o,
  input  logic                        out_ready_i
  );

  logic                     full_r;
  logic [`BRIDGE_LEN_W-1:0] idx_r;
  logic [`BRIDGE_CNT_W-1:0] total_r;
  logic [`BRIDGE_CNT_W-1:0] last_idx;
  logic [`BRIDGE_HDR_W-1:0] hdr_r;
  lite_data_u               data_r;
  logic                     accept;
  logic                     send;

  // only takes a new message once the last one is fully out
  assign in_ready_o = ~full_r;
  assign accept = in_v_i & in_ready_o;
  assign send = out_v_o & out_ready_i;

  assign out_v_o = full_r;
  assign out_hdr_o = hdr_r;
  assign out_data_o = data_r.beat[idx_r];

  assign last_idx = total_r - 1'b1;
  assign out_last_o = ({1'b0, idx_r} == last_idx);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      full_r <= 1'b0;
      idx_r <= '0;
      total_r <= 1;
    end
    else if (accept)
    begin
      full_r <= 1'b1;
      idx_r <= '0;
      total_r <= beat_count(in_hdr_i, payload_mask_p);
    end
    else if (send)
    begin
      // index only moves on a transfer
      if (out_last_o)
        full_r <= 1'b0;
      else
        idx_r <= idx_r + 1'b1;
    end
  end

  // holding register for the whole lite message
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      hdr_r <= in_hdr_i;
      data_r <= in_data_i;
    end
  end

endmodule

`default_nettype wire

/* logic/msg_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module msg_bridge_top
  import bridge_pkg::*;
  (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // request stream in
  input  logic [`BRIDGE_HDR_W-1:0]    req_hdr_i,
  input  logic [`BRIDGE_STREAM_W-1:0] req_data_i,
  input  logic                        req_v_i,
  output logic                        req_ready_o,

  // lite request out
  output logic [`BRIDGE_HDR_W-1:0]    lite_req_hdr_o,
  output lite_data_u                  lite_req_data_o,
  output logic                        lite_req_v_o,
  input  logic                        lite_req_ready_i,

  // lite response in
  input  logic [`BRIDGE_HDR_W-1:0]    lite_resp_hdr_i,
  input  lite_data_u                  lite_resp_data_i,
  input  logic                        lite_resp_v_i,
  output logic                        lite_resp_ready_o,

  // stream response out
  output logic [`BRIDGE_HDR_W-1:0]    resp_hdr_o,
  output logic [`BRIDGE_STREAM_W-1:0] resp_data_o,
  output logic                        resp_last_o,
  output logic                        resp_v_o,
  input  logic                        resp_ready_i
  );

  // writes carry data going out
  stream_to_lite #(.payload_mask_p(`BRIDGE_REQ_PAYLOAD_MASK)) u_req_path
    (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_hdr_i    (req_hdr_i),
    .in_data_i   (req_data_i),
    .in_v_i      (req_v_i),
    .in_ready_o  (req_ready_o),
    .out_hdr_o   (lite_req_hdr_o),
    .out_data_o  (lite_req_data_o),
    .out_v_o     (lite_req_v_o),
    .out_ready_i (lite_req_ready_i)
    );

  // reads carry data coming back
  lite_to_stream #(.payload_mask_p(`BRIDGE_RESP_PAYLOAD_MASK)) u_resp_path
    (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_hdr_i    (lite_resp_hdr_i),
    .in_data_i   (lite_resp_data_i),
    .in_v_i      (lite_resp_v_i),
    .in_ready_o  (lite_resp_ready_o),
    .out_hdr_o   (resp_hdr_o),
    .out_data_o  (resp_data_o),
    .out_last_o  (resp_last_o),
    .out_v_o     (resp_v_o),
    .out_ready_i (resp_ready_i)
    );

endmodule

`default_nettype wire

/* tests/msg_bridge_checks.svh */
`ifndef MSG_BRIDGE_CHECKS_SVH
`define MSG_BRIDGE_CHECKS_SVH

// expected traffic on both output channels, oldest at the head
logic [`BRIDGE_HDR_W-1:0]    exp_req_hdr[$];
lite_data_u                  exp_req_data[$];
logic [`BRIDGE_HDR_W-1:0]    exp_beat_hdr[$];
logic [`BRIDGE_STREAM_W-1:0] exp_beat_data[$];
logic                        exp_beat_last[$];
int                          mismatches = 0;

// beats per message from the type and size fields
function automatic int expected_beats(input logic [`BRIDGE_HDR_W-1:0]  hdr,
                                      input logic [`BRIDGE_MASK_W-1:0] mask);
  int n;
  if (!mask[hdr[`BRIDGE_TYPE_LSB +: `BRIDGE_TYPE_W]])
    return 1;
  // size is log2 of the byte count, 8 bytes per beat
  n = (1 << hdr[`BRIDGE_SIZE_LSB +: `BRIDGE_SIZE_W]) / 8;
  if (n < 1)
    n = 1;
  if (n > `BRIDGE_BEATS)
    n = `BRIDGE_BEATS;
  return n;
endfunction

// expected lite word, first n beats from the low end and zeros above
function automatic lite_data_u pack_beats(
  input logic [`BRIDGE_BEATS-1:0][`BRIDGE_STREAM_W-1:0] raw,
  input int                                             n);
  lite_data_u packed_w;
  packed_w.word = '0;
  for (int k = 0; k < n; k++)
    packed_w.word[k*`BRIDGE_STREAM_W +: `BRIDGE_STREAM_W] = raw[k];
  return packed_w;
endfunction

task automatic check_lite_req(input logic [`BRIDGE_HDR_W-1:0] hdr, input lite_data_u data);
  logic [`BRIDGE_HDR_W-1:0] want_hdr;
  lite_data_u               want_data;
  if (exp_req_hdr.size() == 0)
  begin
    mismatches++;
    $display("lite request %h came out at %0t with nothing outstanding", hdr, $time);
  end
  else
  begin
    want_hdr = exp_req_hdr.pop_front();
    want_data = exp_req_data.pop_front();
    if (hdr !== want_hdr || data !== want_data)
    begin
      mismatches++;
      $display("FAILED at %0t: lite request hdr %h data %h, expected hdr %h data %h",
               $time, hdr, data.word, want_hdr, want_data.word);
    end
  end
endtask

task automatic check_stream_beat(input logic [`BRIDGE_HDR_W-1:0]    hdr,
                                 input logic [`BRIDGE_STREAM_W-1:0] data,
                                 input logic                        last);
  logic [`BRIDGE_HDR_W-1:0]    want_hdr;
  logic [`BRIDGE_STREAM_W-1:0] want_data;
  logic                        want_last;
  if (exp_beat_hdr.size() == 0)
  begin
    mismatches++;
    $display("stream beat %h came out at %0t with nothing outstanding", data, $time);
  end
  else
  begin
    want_hdr = exp_beat_hdr.pop_front();
    want_data = exp_beat_data.pop_front();
    want_last = exp_beat_last.pop_front();
    if (hdr !== want_hdr || data !== want_data || last !== want_last)
    begin
      mismatches++;
      $display("FAILED at %0t: beat hdr %h data %h last %b, expected hdr %h data %h last %b",
               $time, hdr, data, last, want_hdr, want_data, want_last);
    end
  end
endtask

// handshake rules on the output side
task automatic check_rule(input bit ok, input string what);
  if (!ok)
  begin
    mismatches++;
    $display("FAILED at %0t: %s", $time, what);
  end
endtask

`endif

/* tests/msg_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module msg_bridge_tb
  import bridge_pkg::*;
  ();

  localparam int TIMEOUT = 200;

  logic                        clk_i;
  logic                        rst_n_i;
  logic [`BRIDGE_HDR_W-1:0]    req_hdr_i;
  logic [`BRIDGE_STREAM_W-1:0] req_data_i;
  logic                        req_v_i;
  logic                        req_ready_o;
  logic [`BRIDGE_HDR_W-1:0]    lite_req_hdr_o;
  lite_data_u                  lite_req_data_o;
  logic                        lite_req_v_o;
  logic                        lite_req_ready_i;
  logic [`BRIDGE_HDR_W-1:0]    lite_resp_hdr_i;
  lite_data_u                  lite_resp_data_i;
  logic                        lite_resp_v_i;
  logic                        lite_resp_ready_o;
  logic [`BRIDGE_HDR_W-1:0]    resp_hdr_o;
  logic [`BRIDGE_STREAM_W-1:0] resp_data_o;
  logic                        resp_last_o;
  logic                        resp_v_o;
  logic                        resp_ready_i;

  integer seed;
  int     stall_pct = 0;
  int     req_sent = 0;
  int     resp_sent = 0;
  int     req_done = 0;
  int     resp_done = 0;
  int     count_errors = 0;
  int     stalls = 0;
  bit     abort = 1'b0;

  // monitor copies of a beat or request that was stalled last cycle
  bit                          req_held = 1'b0;
  logic [`BRIDGE_HDR_W-1:0]    held_req_hdr;
  lite_data_u                  held_req_data;
  bit                          resp_held = 1'b0;
  logic [`BRIDGE_HDR_W-1:0]    held_resp_hdr;
  logic [`BRIDGE_STREAM_W-1:0] held_resp_data;
  logic                        held_resp_last;

  `include "msg_bridge_checks.svh"

  msg_bridge_top u_dut
    (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .req_hdr_i         (req_hdr_i),
    .req_data_i        (req_data_i),
    .req_v_i           (req_v_i),
    .req_ready_o       (req_ready_o),
    .lite_req_hdr_o    (lite_req_hdr_o),
    .lite_req_data_o   (lite_req_data_o),
    .lite_req_v_o      (lite_req_v_o),
    .lite_req_ready_i  (lite_req_ready_i),
    .lite_resp_hdr_i   (lite_resp_hdr_i),
    .lite_resp_data_i  (lite_resp_data_i),
    .lite_resp_v_i     (lite_resp_v_i),
    .lite_resp_ready_o (lite_resp_ready_o),
    .resp_hdr_o        (resp_hdr_o),
    .resp_data_o       (resp_data_o),
    .resp_last_o       (resp_last_o),
    .resp_v_o          (resp_v_o),
    .resp_ready_i      (resp_ready_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic report_stall(input string what);
    stalls++;
    abort = 1'b1;
    $display("timeout at %0t: %s", $time, what);
  endtask

  // compares every transfer on both output channels
  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      check_rule(!(lite_req_v_o && req_ready_o), "request input ready while a message is held");
      check_rule(!(resp_v_o && lite_resp_ready_o), "lite response ready before the final beat");
      if (req_held)
        check_rule(lite_req_v_o && lite_req_hdr_o === held_req_hdr
                   && lite_req_data_o === held_req_data, "stalled lite request changed");
      if (resp_held)
        check_rule(resp_v_o && resp_hdr_o === held_resp_hdr && resp_data_o === held_resp_data
                   && resp_last_o === held_resp_last, "stalled stream beat changed");
      if (lite_req_v_o && lite_req_ready_i)
      begin
        check_lite_req(lite_req_hdr_o, lite_req_data_o);
        req_done++;
      end
      if (resp_v_o && resp_ready_i)
      begin
        check_stream_beat(resp_hdr_o, resp_data_o, resp_last_o);
        if (resp_last_o)
          resp_done++;
      end
      req_held = lite_req_v_o && !lite_req_ready_i;
      held_req_hdr = lite_req_hdr_o;
      held_req_data = lite_req_data_o;
      resp_held = resp_v_o && !resp_ready_i;
      held_resp_hdr = resp_hdr_o;
      held_resp_data = resp_data_o;
      held_resp_last = resp_last_o;
    end
  end

  // output side back-pressure in random stretches
  initial
  begin : ready_driver
    int stretch;
    stretch = 0;
    lite_req_ready_i = 1'b1;
    resp_ready_i = 1'b1;
    forever
    begin
      @(negedge clk_i);
      if (stretch > 0)
        stretch--;
      else
      begin
        lite_req_ready_i = (rand_below(100) >= stall_pct);
        resp_ready_i = (rand_below(100) >= stall_pct);
        stretch = rand_below(4);
      end
    end
  end

  task automatic send_request(input logic [2:0] msg_type, input logic [2:0] size, input int gap);
    logic [`BRIDGE_HDR_W-1:0]                      hdr;
    logic [`BRIDGE_BEATS-1:0][`BRIDGE_STREAM_W-1:0] raw;
    int                                            n;
    int                                            wait_cnt;
    hdr = {msg_type, size, $random(seed)};
    n = expected_beats(hdr, `BRIDGE_REQ_PAYLOAD_MASK);
    for (int k = 0; k < `BRIDGE_BEATS; k++)
      raw[k] = {$random(seed), $random(seed)};
    exp_req_hdr.push_back(hdr);
    exp_req_data.push_back(pack_beats(raw, n));
    req_sent++;
    for (int k = 0; k < n && !abort; k++)
    begin
      req_hdr_i = hdr;
      req_data_i = raw[k];
      req_v_i = 1'b1;
      wait_cnt = 0;
      // ready only moves on a rising edge, so it holds from here to the transfer
      while (!req_ready_o && !abort)
      begin
        @(negedge clk_i);
        wait_cnt++;
        if (wait_cnt > TIMEOUT)
          report_stall("request stream input never became ready");
      end
      @(negedge clk_i);
    end
    req_v_i = 1'b0;
    repeat (gap) @(negedge clk_i);
  endtask

  task automatic send_response(input logic [2:0] msg_type, input logic [2:0] size, input int gap);
    logic [`BRIDGE_HDR_W-1:0] hdr;
    lite_data_u               data;
    int                       n;
    int                       wait_cnt;
    hdr = {msg_type, size, $random(seed)};
    for (int k = 0; k < `BRIDGE_LITE_W / 32; k++)
      data.word[k*32 +: 32] = $random(seed);
    n = expected_beats(hdr, `BRIDGE_RESP_PAYLOAD_MASK);
    for (int k = 0; k < n; k++)
    begin
      exp_beat_hdr.push_back(hdr);
      exp_beat_data.push_back(data.word[k*`BRIDGE_STREAM_W +: `BRIDGE_STREAM_W]);
      exp_beat_last.push_back(k == n - 1);
    end
    resp_sent++;
    lite_resp_hdr_i = hdr;
    lite_resp_data_i = data;
    lite_resp_v_i = 1'b1;
    wait_cnt = 0;
    while (!lite_resp_ready_o && !abort)
    begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > TIMEOUT)
        report_stall("lite response input never became ready");
    end
    @(negedge clk_i);
    lite_resp_v_i = 1'b0;
    repeat (gap) @(negedge clk_i);
  endtask

  task automatic wait_drained();
    int wait_cnt;
    wait_cnt = 0;
    while ((exp_req_hdr.size() != 0 || exp_beat_hdr.size() != 0) && !abort)
    begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > TIMEOUT * 4)
        report_stall("expected outputs never drained");
    end
  endtask

  initial
  begin
    seed = 32'h1dcf;
    rst_n_i = 1'b0;
    req_hdr_i = '0;
    req_data_i = '0;
    req_v_i = 1'b0;
    lite_resp_hdr_i = '0;
    lite_resp_data_i = '0;
    lite_resp_v_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (!(req_ready_o && lite_resp_ready_o && !lite_req_v_o && !resp_v_o))
    begin
      count_errors++;
      $display("FAILED at %0t: reset state ready %b %b valid %b %b", $time,
               req_ready_o, lite_resp_ready_o, lite_req_v_o, resp_v_o);
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);
    // every type and size, one path at a time, no back-pressure
    for (int t = 0; t < 4; t++)
      for (int s = 0; s < 6; s++)
        send_request(3'(t), 3'(s), 1);
    wait_drained();
    for (int t = 0; t < 4; t++)
      for (int s = 0; s < 6; s++)
        send_response(3'(t), 3'(s), 1);
    wait_drained();
    // both paths together with stalls and random gaps
    stall_pct = 40;
    fork
      repeat (40) send_request(3'(rand_below(4)), 3'(rand_below(6)), rand_below(3));
      repeat (40) send_response(3'(rand_below(4)), 3'(rand_below(6)), rand_below(3));
    join
    wait_drained();
    if (req_done != req_sent || resp_done != resp_sent)
    begin
      count_errors++;
      $display("FAILED at %0t: completed %0d of %0d requests and %0d of %0d responses",
               $time, req_done, req_sent, resp_done, resp_sent);
    end
    $display("mismatches %0d, count errors %0d, timeouts %0d", mismatches, count_errors, stalls);
    if (mismatches == 0 && count_errors == 0 && stalls == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* msg_bridge.f */
+incdir+logic
+incdir+tests
logic/bridge_pkg.sv
logic/msg_one_fifo.sv
logic/stream_sipo_dynamic.sv
logic/stream_to_lite.sv
logic/lite_to_stream.sv
logic/msg_bridge_top.sv
tests/msg_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module msg_bridge_tb \
  -f msg_bridge.f \
  -o msg_bridge_sim

output=$(./obj_dir/msg_bridge_sim)
echo "$output"

# the run passes only if the pass message was printed
if grep -q "Test completed successfully" <<< "$output"; then
  exit 0
fi
exit 1
